/* logic/xc_pkg.sv */
/*
 * XC correlator shared definitions.
 * Byte type, frame header and the UART character framing.
 */

package xc_pkg;

	// One character on the serial line.
	typedef logic [7:0] uart_byte_t;

	// Leading byte of every count frame.
	localparam uart_byte_t FRAME_HEADER = 8'h5a;

	// Start, eight data bits, stop.
	localparam int UART_BITS = 10;

	// Line levels of the framing bits.
	localparam logic START_BIT = 1'b0;
	localparam logic STOP_BIT  = 1'b1; // Also the idle level.

endpackage

/* logic/line_sampler.sv */
/*
 * Line sampler.
 * Syncs the photon lines and the strobe into sysclk, decimates the lines
 * to the sample rate and turns the strobe into a one-cycle clear.
 */

module line_sampler #(
	parameter int NUM_LINES  = 4,
	parameter int SAMPLE_DIV = 8
) (
	input  logic                 sysclk,
	input  logic                 rst,
	input  logic [NUM_LINES-1:0] lines,
	input  logic                 strobe,
	output logic [NUM_LINES-1:0] sample,
	output logic                 sample_tick,
	output logic                 sync_clear
);

	localparam int DIV_W = $clog2(SAMPLE_DIV);

	logic [NUM_LINES-1:0] lines_s1, lines_s2; // Line synchronizer.
	logic                 strobe_s1, strobe_s2, strobe_s3; // Strobe sync plus edge flop.
	logic [DIV_W-1:0]     div_cnt; // Sample divider.

	wire div_wrap = (div_cnt == DIV_W'(SAMPLE_DIV - 1));

	// Line synchronizer and sample register.
	always_ff @(posedge sysclk) begin
		lines_s1 <= lines;
		lines_s2 <= lines_s1;
		if (div_wrap)
			sample <= lines_s2; // Held until the next tick.
	end

	always_ff @(posedge sysclk) begin
		if (rst) begin
			strobe_s1   <= 1'b0;
			strobe_s2   <= 1'b0;
			strobe_s3   <= 1'b0;
			div_cnt     <= '0;
			sample_tick <= 1'b0;
			sync_clear  <= 1'b0;
		end else begin
			strobe_s1   <= strobe;
			strobe_s2   <= strobe_s1;
			strobe_s3   <= strobe_s2;
			sync_clear  <= strobe_s2 & ~strobe_s3; // Rising edge only.
			sample_tick <= div_wrap; // Aligned with the new sample.
			div_cnt     <= div_wrap ? '0 : div_cnt + 1'b1;
		end
	end

endmodule

/* logic/correlator.sv */
/*
 * Lag-zero correlator.
 * Saturating per-line and per-pair coincidence counters over a window
 * of INTEGRATION samples, frozen into a snapshot at each window end.
 */

module correlator #(
	parameter int NUM_LINES   = 4,
	parameter int RESOLUTION  = 16,
	parameter int INTEGRATION = 64
) (
	input  logic                                   sysclk,
	input  logic                                   rst,
	input  logic [NUM_LINES-1:0]                   sample,
	input  logic                                   sample_tick,
	input  logic                                   sync_clear,
	output logic [NUM_LINES-1:0][RESOLUTION-1:0]   auto_counts,
	output logic [NUM_LINES*(NUM_LINES-1)/2-1:0][RESOLUTION-1:0] cross_counts,
	output logic                                   frame_ready
);

	localparam int NUM_PAIRS = NUM_LINES * (NUM_LINES - 1) / 2;
	localparam int WIN_W     = $clog2(INTEGRATION + 1);

	logic [NUM_LINES-1:0][RESOLUTION-1:0] auto_cnt, auto_nxt; // Live and next auto counts.
	logic [NUM_PAIRS-1:0][RESOLUTION-1:0] cross_cnt, cross_nxt; // Live and next pair counts.
	logic [WIN_W-1:0]                     win_cnt; // Samples taken in this window.

	wire win_last = (win_cnt == WIN_W'(INTEGRATION - 1));
	wire win_end  = sample_tick & ~sync_clear & win_last; // Clear beats the tick.

	// Adds one on a hit, sticks at all ones.
	function automatic logic [RESOLUTION-1:0] sat_inc(input logic [RESOLUTION-1:0] cnt,
		input logic hit);
		return (hit && cnt != '1) ? cnt + 1'b1 : cnt;
	endfunction

	for (genvar i = 0; i < NUM_LINES; i++) begin : g_auto
		assign auto_nxt[i] = sat_inc(auto_cnt[i], sample[i]);
	end

	// Pair (i,j), i<j, in lexicographic order.
	for (genvar i = 0; i < NUM_LINES - 1; i++) begin : g_row
		for (genvar j = i + 1; j < NUM_LINES; j++) begin : g_col
			localparam int PAIR = i * NUM_LINES - i * (i + 1) / 2 + (j - i - 1);
			assign cross_nxt[PAIR] = sat_inc(cross_cnt[PAIR], sample[i] & sample[j]);
		end
	end

	always_ff @(posedge sysclk) begin
		if (rst) begin
			auto_cnt    <= '0;
			cross_cnt   <= '0;
			win_cnt     <= '0;
			frame_ready <= 1'b0;
		end else begin
			frame_ready <= win_end; // One clock after the final tick.
			if (sync_clear) begin
				auto_cnt  <= '0; // Partial window is discarded.
				cross_cnt <= '0;
				win_cnt   <= '0;
			end else if (sample_tick) begin
				if (win_last) begin
					auto_cnt  <= '0; // Next window starts from zero.
					cross_cnt <= '0;
					win_cnt   <= '0;
				end else begin
					auto_cnt  <= auto_nxt;
					cross_cnt <= cross_nxt;
					win_cnt   <= win_cnt + 1'b1;
				end
			end
		end
	end

	// Snapshot takes the counts including the final sample.
	always_ff @(posedge sysclk) begin
		if (win_end) begin
			auto_counts  <= auto_nxt;
			cross_counts <= cross_nxt;
		end
	end

endmodule

/* logic/frame_packer.sv */
/*
 * Frame packer.
 * Copies a snapshot with its header into a frame register and feeds it
 * to the UART one byte at a time, MSB first. Flags snapshots it misses.
 */

module frame_packer import xc_pkg::*; #(
	parameter int NUM_LINES  = 4,
	parameter int RESOLUTION = 16
) (
	input  logic                                   sysclk,
	input  logic                                   rst,
	input  logic [NUM_LINES-1:0][RESOLUTION-1:0]   auto_counts,
	input  logic [NUM_LINES*(NUM_LINES-1)/2-1:0][RESOLUTION-1:0] cross_counts,
	input  logic                                   frame_ready,
	input  logic                                   busy,
	output uart_byte_t                             byte_data,
	output logic                                   byte_valid,
	output logic                                   overrun
);

	localparam int NUM_PAIRS   = NUM_LINES * (NUM_LINES - 1) / 2;
	localparam int COUNT_BITS  = (NUM_LINES + NUM_PAIRS) * RESOLUTION;
	localparam int FRAME_BITS  = COUNT_BITS + 8;
	localparam int FRAME_BYTES = FRAME_BITS / 8;
	localparam int IDX_W       = $clog2(FRAME_BYTES);

	logic [FRAME_BITS-1:0] flat; // Snapshot laid out in send order.
	logic [FRAME_BITS-1:0] frame_sr; // Private copy, next byte on top.
	logic [IDX_W-1:0]      idx; // Bytes issued so far.
	logic                  active; // Frame in progress.
	logic                  issued; // Byte went out last cycle.

	wire accept = frame_ready & ~active;

	// Header, then auto counts, then pairs, each count big-endian.
	assign flat[FRAME_BITS-1 -: 8] = FRAME_HEADER;
	for (genvar k = 0; k < NUM_LINES; k++) begin : g_auto
		assign flat[COUNT_BITS-1 - k*RESOLUTION -: RESOLUTION] = auto_counts[k];
	end
	for (genvar p = 0; p < NUM_PAIRS; p++) begin : g_cross
		assign flat[COUNT_BITS-1 - (NUM_LINES+p)*RESOLUTION -: RESOLUTION] = cross_counts[p];
	end

	assign byte_valid = active & ~busy & ~issued; // Wait for the UART.
	assign byte_data  = frame_sr[FRAME_BITS-1 -: 8];

	always_ff @(posedge sysclk) begin
		if (accept)
			frame_sr <= flat;
		else if (byte_valid)
			frame_sr <= frame_sr << 8; // Bring up the next byte.
	end

	always_ff @(posedge sysclk) begin
		if (rst) begin
			active  <= 1'b0;
			idx     <= '0;
			issued  <= 1'b0;
			overrun <= 1'b0;
		end else begin
			issued  <= byte_valid;
			overrun <= frame_ready & active; // Snapshot dropped.
			if (accept) begin
				active <= 1'b1;
				idx    <= '0;
			end else if (byte_valid) begin
				if (idx == IDX_W'(FRAME_BYTES - 1))
					active <= 1'b0; // Last byte handed over.
				idx <= idx + 1'b1;
			end
		end
	end

endmodule

/* logic/uart_tx.sv */
/*
 * UART transmitter, 8N1.
 * Shifts out start, data LSB first and stop at CLKS_PER_BIT clocks per bit.
 */

module uart_tx import xc_pkg::*; #(
	parameter int CLKS_PER_BIT = 4
) (
	input  logic       sysclk,
	input  logic       rst,
	input  uart_byte_t byte_data,
	input  logic       byte_valid,
	output logic       tx,
	output logic       busy
);

	localparam int TMR_W = $clog2(CLKS_PER_BIT + 1);
	localparam int CNT_W = $clog2(UART_BITS);

	logic [UART_BITS-1:0] shreg; // Bit 0 drives the line.
	logic [TMR_W-1:0]     tmr; // Clocks into the current bit.
	logic [CNT_W-1:0]     bit_cnt; // Bits finished.

	wire bit_end = (tmr == TMR_W'(CLKS_PER_BIT - 1));

	assign tx = shreg[0];

	always_ff @(posedge sysclk) begin
		if (rst) begin
			shreg   <= '1; // Line idles high.
			tmr     <= '0;
			bit_cnt <= '0;
			busy    <= 1'b0;
		end else if (!busy) begin
			if (byte_valid) begin
				shreg   <= {STOP_BIT, byte_data, START_BIT};
				tmr     <= '0;
				bit_cnt <= '0;
				busy    <= 1'b1;
			end
		end else if (bit_end) begin
			tmr     <= '0;
			shreg   <= {STOP_BIT, shreg[UART_BITS-1:1]}; // Fill with idle level.
			bit_cnt <= bit_cnt + 1'b1;
			if (bit_cnt == CNT_W'(UART_BITS - 1))
				busy <= 1'b0; // Stop bit done.
		end else begin
			tmr <= tmr + 1'b1;
		end
	end

endmodule

/* logic/xc_firmware.sv */
/*
 * XC correlator top level.
 * Sampler, lag-zero correlator, frame packer and UART in a chain.
 */

module xc_firmware import xc_pkg::*; #(
	parameter int NUM_LINES    = 4,
	parameter int RESOLUTION   = 16,
	parameter int SAMPLE_DIV   = 8,
	parameter int INTEGRATION  = 64,
	parameter int CLKS_PER_BIT = 4
) (
	input  logic                 sysclk,
	input  logic                 rst,
	input  logic [NUM_LINES-1:0] lines,
	input  logic                 strobe,
	output logic                 tx,
	output logic                 smpclk,
	output logic                 overrun
);

	localparam int NUM_PAIRS = NUM_LINES * (NUM_LINES - 1) / 2;

	logic [NUM_LINES-1:0]                 sample; // Decimated lines.
	logic                                 sync_clear; // Strobe edge.
	logic [NUM_LINES-1:0][RESOLUTION-1:0] auto_counts; // Snapshot.
	logic [NUM_PAIRS-1:0][RESOLUTION-1:0] cross_counts;
	logic                                 frame_ready;
	uart_byte_t                           byte_data;
	logic                                 byte_valid;
	logic                                 busy; // Only backward signal.

	line_sampler #(.NUM_LINES(NUM_LINES), .SAMPLE_DIV(SAMPLE_DIV)) sampler_i (
		.sysclk(sysclk), .rst(rst), .lines(lines), .strobe(strobe),
		.sample(sample), .sample_tick(smpclk), .sync_clear(sync_clear)
	);

	correlator #(.NUM_LINES(NUM_LINES), .RESOLUTION(RESOLUTION),
		.INTEGRATION(INTEGRATION)) correlator_i (
		.sysclk(sysclk), .rst(rst), .sample(sample), .sample_tick(smpclk),
		.sync_clear(sync_clear), .auto_counts(auto_counts),
		.cross_counts(cross_counts), .frame_ready(frame_ready)
	);

	frame_packer #(.NUM_LINES(NUM_LINES), .RESOLUTION(RESOLUTION)) packer_i (
		.sysclk(sysclk), .rst(rst), .auto_counts(auto_counts),
		.cross_counts(cross_counts), .frame_ready(frame_ready), .busy(busy),
		.byte_data(byte_data), .byte_valid(byte_valid), .overrun(overrun)
	);

	uart_tx #(.CLKS_PER_BIT(CLKS_PER_BIT)) uart_i (
		.sysclk(sysclk), .rst(rst), .byte_data(byte_data),
		.byte_valid(byte_valid), .tx(tx), .busy(busy)
	);

endmodule

/* dv/xc_assert.sv */
/*
 * Protocol checks for the UART transmitter and the frame packer.
 * The idle-line check applies only where the serial line exists.
 */

module xc_assert #(
	parameter bit CHECK_LINE = 1'b1
) (
	input logic sysclk,
	input logic rst,
	input logic tx,
	input logic busy,
	input logic byte_valid
);

	// Idle line sits at the stop level.
	a_idle_high: assert property (@(posedge sysclk) disable iff (rst || !CHECK_LINE)
		!busy |-> tx)
		else $error("tx low while the UART is idle");

	// A byte is only offered to an idle UART.
	a_no_push_busy: assert property (@(posedge sysclk) disable iff (rst)
		$rose(byte_valid) |-> !busy)
		else $error("byte_valid rose while busy");

	a_single_pulse: assert property (@(posedge sysclk) disable iff (rst)
		byte_valid |=> !byte_valid)
		else $error("byte_valid held longer than one cycle");

endmodule

bind uart_tx xc_assert #(.CHECK_LINE(1'b1)) uart_chk_i (
	.sysclk(sysclk), .rst(rst), .tx(tx), .busy(busy), .byte_valid(byte_valid));

bind frame_packer xc_assert #(.CHECK_LINE(1'b0)) packer_chk_i (
	.sysclk(sysclk), .rst(rst), .tx(1'b1), .busy(busy), .byte_valid(byte_valid));

/* dv/xc_tb.sv */
/*
 * XC correlator testbench.
 * Table-driven line stimulus, a lag-zero counting model and a UART decoder
 * that checks every received frame against the window it carries.
 */

module xc_tb import xc_pkg::*; #(
	parameter int INTEGRATION = 8
);

	localparam int NUM_LINES     = 4;
	localparam int RESOLUTION    = 16;
	localparam int SAMPLE_DIV    = 8;
	localparam int CLKS_PER_BIT  = 4;
	localparam int PERIOD        = 4;
	localparam int NUM_PAIRS     = NUM_LINES * (NUM_LINES - 1) / 2;
	localparam int NUM_COUNTS    = NUM_LINES + NUM_PAIRS;
	localparam int BYTES_PER_CNT = RESOLUTION / 8;
	localparam int FRAME_BYTES   = 1 + NUM_COUNTS * BYTES_PER_CNT;
	localparam int FRAME_CLKS    = FRAME_BYTES * UART_BITS * CLKS_PER_BIT;
	localparam bit EXPECT_OVERRUN = INTEGRATION * SAMPLE_DIV < FRAME_CLKS; // Windows outpace frames.
	localparam uart_byte_t HEADER = 8'h5a;

	// Row layout {hold samples, strobe, random, 2'b0, pattern}.
	localparam int NUM_ROWS = 7;
	localparam logic [15:0] ROWS [NUM_ROWS] = '{
		{8'd120, 1'b0, 1'b0, 2'b0, 4'hf}, // All lines high.
		{8'd120, 1'b0, 1'b0, 2'b0, 4'ha}, // Alternating lines.
		{8'd120, 1'b0, 1'b0, 2'b0, 4'h4}, // Line 2 alone.
		{8'd240, 1'b0, 1'b1, 2'b0, 4'h0}, // LFSR patterns.
		{8'd26,  1'b0, 1'b0, 2'b0, 4'h3}, // Partial window, strobed away as the packer frees up.
		{8'd120, 1'b1, 1'b0, 2'b0, 4'h5}, // Strobe lands mid-window.
		{8'd120, 1'b0, 1'b1, 2'b0, 4'h0}
	};

	logic                 sysclk = 1'b0;
	logic                 rst = 1'b1;
	logic [NUM_LINES-1:0] lines;
	logic                 strobe;
	logic                 tx, smpclk, overrun;

	logic [RESOLUTION-1:0] acc_auto [NUM_LINES]; // Model counters.
	logic [RESOLUTION-1:0] acc_cross [NUM_PAIRS];
	logic [NUM_COUNTS*RESOLUTION-1:0] win_q [$]; // Finished windows, count k at k*RESOLUTION.
	time                  win_t [$]; // When each window finished.
	time                  idle_from = 0; // Earliest window the packer may take next.
	int                   win_fill = 0;
	int                   frames_done = 0;
	logic [NUM_LINES-1:0] cur = '0; // Value the next tick takes.
	logic [31:0]          lfsr = 32'h4f1;
	bit                   overrun_seen = 1'b0;

	xc_firmware #(.NUM_LINES(NUM_LINES), .RESOLUTION(RESOLUTION), .SAMPLE_DIV(SAMPLE_DIV),
		.INTEGRATION(INTEGRATION), .CLKS_PER_BIT(CLKS_PER_BIT)) dut_i (
		.sysclk(sysclk), .rst(rst), .lines(lines), .strobe(strobe),
		.tx(tx), .smpclk(smpclk), .overrun(overrun)
	);

	always #(PERIOD / 2) sysclk = ~sysclk;

	always @(negedge sysclk) begin
		if (!rst && overrun === 1'b1)
			overrun_seen <= 1'b1;
	end

	// Galois form, taps for x^32 + x^22 + x^2 + x + 1.
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return s[0] ? (s >> 1) ^ 32'h8020_0003 : s >> 1;
	endfunction

	task automatic fail_run(input string why);
		$display("%s", why);
		$display("test failed");
		$fatal(1);
	endtask

	task automatic check_byte(input string name, input uart_byte_t got, input uart_byte_t exp);
		if (got !== exp)
			fail_run($sformatf("** Error: %s got %h expected %h", name, got, exp));
	endtask

	task automatic check_count(input string name, input logic [RESOLUTION-1:0] got,
		input logic [RESOLUTION-1:0] exp);
		if (got !== exp)
			fail_run($sformatf("** Error: %s got %h expected %h", name, got, exp));
	endtask

	task automatic check_period(input string name, input int got, input int exp);
		if (got !== exp)
			fail_run($sformatf("** Error: %s got %h expected %h", name, got, exp));
	endtask

	task automatic clear_window();
		for (int i = 0; i < NUM_LINES; i++)
			acc_auto[i] = '0;
		for (int p = 0; p < NUM_PAIRS; p++)
			acc_cross[p] = '0;
		win_fill = 0;
	endtask

	// Counts the sample a tick just took and closes the window when full.
	task automatic count_sample();
		logic [NUM_COUNTS*RESOLUTION-1:0] wv;
		int p;
		p = 0;
		for (int i = 0; i < NUM_LINES; i++) begin
			if (cur[i] && acc_auto[i] != '1)
				acc_auto[i] = acc_auto[i] + 1'b1; // Saturates at all ones.
			for (int j = i + 1; j < NUM_LINES; j++) begin
				if (cur[i] && cur[j] && acc_cross[p] != '1)
					acc_cross[p] = acc_cross[p] + 1'b1;
				p++; // Pairs in (0,1), (0,2) ... order.
			end
		end
		win_fill++;
		if (win_fill == INTEGRATION) begin
			for (int i = 0; i < NUM_LINES; i++)
				wv[i*RESOLUTION +: RESOLUTION] = acc_auto[i];
			for (int q = 0; q < NUM_PAIRS; q++)
				wv[(NUM_LINES+q)*RESOLUTION +: RESOLUTION] = acc_cross[q];
			win_q.push_back(wv);
			win_t.push_back($time);
			clear_window();
		end
	endtask

	// Waits for a tick, books it, then drives the next value.
	task automatic step_sample(input logic [NUM_LINES-1:0] pattern, input logic clear);
		int gap;
		gap = 0;
		do begin
			@(negedge sysclk);
			gap++;
		end while (smpclk !== 1'b1);
		check_period("smpclk period", gap, SAMPLE_DIV); // One single-cycle tick per divider turn.
		count_sample();
		lines  = pattern;
		strobe = clear; // Held for one sample period.
		cur    = pattern;
		if (clear)
			clear_window(); // This value opens the new window.
	endtask

	initial begin : stimulus
		logic [NUM_LINES-1:0] pattern;
		int target;
		lines  = '0;
		strobe = 1'b0;
		clear_window();
		repeat (16) @(posedge sysclk);
		@(negedge sysclk);
		rst = 1'b0;
		for (int r = 0; r < NUM_ROWS; r++) begin
			for (int s = 0; s < int'(ROWS[r][15:8]); s++) begin
				pattern = ROWS[r][3:0];
				if (ROWS[r][6]) begin
					for (int b = 0; b < NUM_LINES; b++) begin
						lfsr = lfsr_next(lfsr); // One step per bit.
						pattern[b] = lfsr[0];
					end
				end
				step_sample(pattern, ROWS[r][7] && s == 0);
			end
		end
		target = frames_done + 2; // Frame in flight plus one full frame.
		while (frames_done < target)
			step_sample('0, 1'b0);
		if (EXPECT_OVERRUN && !overrun_seen)
			fail_run("overrun never pulsed although windows end during frames");
		else begin
			$display("test passed");
			$finish;
		end
	end

	initial begin : decoder
		logic [NUM_COUNTS*RESOLUTION-1:0] exp_win;
		logic [RESOLUTION-1:0] cnt;
		uart_byte_t rx;
		time t_start;
		int bi;
		int k;
		bi  = 0;
		cnt = '0;
		wait (rst === 1'b0);
		forever begin
			do @(negedge sysclk); while (tx !== 1'b0);
			t_start = $time; // Half a clock into the start bit.
			if (bi == 0) begin
				while (win_t.size() > 0 && win_t[0] < idle_from) begin
					win_q.delete(0); // Dropped by overrun.
					win_t.delete(0);
				end
				if (win_q.size() == 0)
					fail_run("frame started on tx with no finished window to carry");
				exp_win = win_q[0];
				win_q.delete(0);
				win_t.delete(0);
			end
			repeat (CLKS_PER_BIT / 2) @(negedge sysclk);
			if (tx !== 1'b0)
				fail_run("start bit on tx ended early");
			for (int b = 0; b < 8; b++) begin
				repeat (CLKS_PER_BIT) @(negedge sysclk);
				rx[b] = tx; // LSB first.
			end
			repeat (CLKS_PER_BIT) @(negedge sysclk);
			if (tx !== 1'b1)
				fail_run("framing error, the stop bit on tx was low");
			if (bi == 0)
				check_byte("header", rx, HEADER);
			else begin
				cnt = (cnt << 8) | rx; // Big-endian.
				if ((bi - 1) % BYTES_PER_CNT == BYTES_PER_CNT - 1) begin
					k = (bi - 1) / BYTES_PER_CNT;
					if (k < NUM_LINES)
						check_count($sformatf("auto_counts[%0d]", k), cnt,
							exp_win[k*RESOLUTION +: RESOLUTION]);
					else
						check_count($sformatf("cross_counts[%0d]", k - NUM_LINES), cnt,
							exp_win[k*RESOLUTION +: RESOLUTION]);
				end
			end
			if (bi == FRAME_BYTES - 1)
				idle_from = t_start - PERIOD; // Packer frees up as this byte loads.
			bi++;
			if (bi == FRAME_BYTES) begin
				bi = 0;
				frames_done++;
			end
		end
	end

	initial begin : watchdog
		longint limit;
		int samples;
		samples = 0;
		for (int r = 0; r < NUM_ROWS; r++)
			samples += int'(ROWS[r][15:8]);
		// Table plus three frames and a window of tail, doubled.
		limit = 2 * (longint'(samples) * SAMPLE_DIV * PERIOD + 3 * FRAME_CLKS * PERIOD
			+ INTEGRATION * SAMPLE_DIV * PERIOD + 16 * PERIOD);
		#(limit);
		fail_run($sformatf("timeout after %0d time units", limit));
	end

endmodule

/* files.f */
logic/xc_pkg.sv
logic/line_sampler.sv
logic/correlator.sv
logic/frame_packer.sv
logic/uart_tx.sv
logic/xc_firmware.sv
dv/xc_assert.sv
dv/xc_tb.sv
